//--- verilog/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // geometry of the two-way, 8 KB cache
    localparam int LINE_BYTES = 32;
    localparam int LINE_WORDS = 8;
    localparam int OFFSET_W   = 5;
    localparam int INDEX_W    = 7;
    localparam int TAG_W      = 20;
    localparam int SETS       = 128;
    localparam int WAYS       = 2;
    localparam int WORD_SEL_W = 3;

    typedef logic [LINE_BYTES*8-1:0] line_t;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } addr_fields_t;

    // flat byte address on the ports, split fields for lookup
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t fields;
    } cache_addr_u;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_e;

    typedef struct packed {
        op_e         op;
        cache_addr_u addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             valid;
        logic             dirty;
    } tag_entry_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        WRITEBACK,
        REFILL
    } state_e;

endpackage

`default_nettype wire

//--- verilog/refill_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module refill_buffer import cache_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        ret_valid,
    input  logic        ret_last,
    input  logic [31:0] ret_data,
    output line_t       refill_line,
    output logic        fill_done
);

    logic [WORD_SEL_W-1:0]       beat_cnt;
    logic [LINE_WORDS-1:0][31:0] words_q;
    logic [LINE_WORDS-1:0][31:0] words_now;

    // current beat already in place, so the last beat needs no extra cycle
    always_comb begin
        words_now = words_q;
        if (ret_valid) begin
            words_now[beat_cnt] = ret_data;
        end
    end

    assign refill_line = words_now;
    assign fill_done   = ret_valid && ret_last;

    always_ff @(posedge clk) begin
        if (!resetn || fill_done) begin
            beat_cnt <= '0;
            words_q  <= '0;
        end else if (ret_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
            words_q  <= words_now;
        end
    end

endmodule

`default_nettype wire

//--- verilog/tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module tag_store import cache_pkg::*; (
    input  logic               clk,
    input  logic               resetn,
    input  logic               lookup_en,
    input  logic [INDEX_W-1:0] lookup_index,
    input  logic [TAG_W-1:0]   lookup_tag,
    input  logic               wr_en,
    input  logic               wr_way,
    input  logic               wr_dirty,
    output logic               hit,
    output logic               hit_way,
    output tag_entry_t         way_entry [WAYS]
);

    logic [WAYS-1:0] way_match;

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        logic [TAG_W-1:0] tag_mem [SETS];
        logic [SETS-1:0]  valid_bits;
        logic [SETS-1:0]  dirty_bits;
        logic             way_we;

        assign way_we = wr_en && (wr_way == 1'(w));

        always_ff @(posedge clk) begin
            if (way_we) begin
                tag_mem[lookup_index] <= lookup_tag;
            end
        end

        always_ff @(posedge clk) begin
            if (!resetn) begin
                valid_bits <= '0;
            end else if (way_we) begin
                valid_bits[lookup_index] <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (way_we) begin
                dirty_bits[lookup_index] <= wr_dirty;
            end
        end

        // entry read in the accept cycle, used in LOOKUP and MISS
        always_ff @(posedge clk) begin
            if (lookup_en) begin
                way_entry[w].tag   <= tag_mem[lookup_index];
                way_entry[w].valid <= valid_bits[lookup_index];
                way_entry[w].dirty <= dirty_bits[lookup_index];
            end
        end

        assign way_match[w] = way_entry[w].valid && (way_entry[w].tag == lookup_tag);
    end

    assign hit     = |way_match;
    // two ways only, so way 1 matching names the hit way
    assign hit_way = way_match[1];

endmodule

`default_nettype wire

//--- verilog/data_store.sv
`timescale 1ns/1ps
`default_nettype none

module data_store import cache_pkg::*; (
    input  logic               clk,
    input  logic               lookup_en,
    input  logic [INDEX_W-1:0] lookup_index,
    input  logic               hit_way,
    input  logic               wr_en,
    input  logic               wr_way,
    input  logic               from_refill,
    input  cpu_req_t           cur_req,
    input  line_t              refill_line,
    input  logic               victim_way,
    output logic [31:0]        rdata,
    output line_t              victim_line
);

    line_t                       line_q [WAYS];
    line_t                       src_line;
    logic [LINE_WORDS-1:0][31:0] src_words;
    logic [LINE_WORDS-1:0][31:0] merged_words;
    logic [WORD_SEL_W-1:0]       word_sel;
    logic [31:0]                 new_word;

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        line_t line_mem [SETS];

        always_ff @(posedge clk) begin
            if (wr_en && (wr_way == 1'(w))) begin
                line_mem[lookup_index] <= merged_words;
            end
        end

        always_ff @(posedge clk) begin
            if (lookup_en) begin
                line_q[w] <= line_mem[lookup_index];
            end
        end
    end

    assign word_sel  = cur_req.addr.fields.offset[OFFSET_W-1:2];
    assign src_line  = from_refill ? refill_line : line_q[hit_way];
    assign src_words = src_line;

    // store bytes replace the addressed word under wstrb
    always_comb begin
        new_word = src_words[word_sel];
        if (cur_req.op == OP_WRITE) begin
            for (int b = 0; b < 4; b++) begin
                if (cur_req.wstrb[b]) begin
                    new_word[b*8 +: 8] = cur_req.wdata[b*8 +: 8];
                end
            end
        end
    end

    always_comb begin
        merged_words           = src_words;
        merged_words[word_sel] = new_word;
    end

    assign rdata       = new_word;
    assign victim_line = line_q[victim_way];

endmodule

`default_nettype wire

//--- verilog/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl import cache_pkg::*; (
    input  logic               clk,
    input  logic               resetn,
    input  logic               valid,
    input  cpu_req_t           req,
    output logic               addr_ok,
    output logic               data_ok,
    input  logic               hit,
    input  logic               hit_way,
    input  tag_entry_t         way_entry [WAYS],
    input  logic               fill_done,
    input  logic               rd_rdy,
    input  logic               wr_rdy,
    output logic               rd_req,
    output logic               wr_req,
    output logic [31:0]        rd_addr,
    output logic [31:0]        wr_addr,
    output logic               lookup_en,
    output logic [INDEX_W-1:0] lookup_index,
    output logic [TAG_W-1:0]   lookup_tag,
    output logic               wr_en,
    output logic               wr_way,
    output logic               wr_dirty,
    output logic               from_refill,
    output cpu_req_t           cur_req
);

    state_e      state;
    state_e      state_nxt;
    logic        victim;
    logic        rd_sent;
    logic        is_write;
    tag_entry_t  victim_entry;
    cache_addr_u refill_addr;
    cache_addr_u wb_addr;

    // requests only taken while idle
    assign addr_ok      = valid && (state == IDLE);
    assign lookup_en    = addr_ok;
    assign lookup_index = (state == IDLE) ? req.addr.fields.index
                                          : cur_req.addr.fields.index;
    assign lookup_tag   = cur_req.addr.fields.tag;

    assign is_write     = (cur_req.op == OP_WRITE);
    assign victim_entry = way_entry[victim];

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (addr_ok) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                state_nxt = hit ? IDLE : MISS;
            end
            MISS: begin
                // dirty victim goes out before the refill
                if (victim_entry.valid && victim_entry.dirty) begin
                    state_nxt = WRITEBACK;
                end else begin
                    state_nxt = REFILL;
                end
            end
            WRITEBACK: begin
                if (wr_rdy) begin
                    state_nxt = REFILL;
                end
            end
            REFILL: begin
                if (fill_done) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= IDLE;
            victim  <= 1'b0;
            rd_sent <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == REFILL && fill_done) begin
                victim  <= ~victim;
                rd_sent <= 1'b0;
            end else if (rd_req && rd_rdy) begin
                rd_sent <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            cur_req <= req;
        end
    end

    assign data_ok = (state == LOOKUP && hit) || (state == REFILL && fill_done);

    // store hit or refill completion updates both stores
    assign wr_en       = (state == LOOKUP && hit && is_write) || (state == REFILL && fill_done);
    assign wr_way      = (state == LOOKUP) ? hit_way : victim;
    assign wr_dirty    = is_write;
    assign from_refill = (state == REFILL);

    always_comb begin
        refill_addr.fields.tag    = cur_req.addr.fields.tag;
        refill_addr.fields.index  = cur_req.addr.fields.index;
        refill_addr.fields.offset = '0;
        wb_addr.fields.tag        = victim_entry.tag;
        wb_addr.fields.index      = cur_req.addr.fields.index;
        wb_addr.fields.offset     = '0;
    end

    assign rd_addr = refill_addr.raw;
    assign wr_addr = wb_addr.raw;
    assign rd_req  = (state == REFILL) && !rd_sent;
    assign wr_req  = (state == WRITEBACK);

endmodule

`default_nettype wire

//--- verilog/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top import cache_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    // processor side
    input  logic        valid,
    input  cpu_req_t    req,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [31:0] rdata,
    // memory read
    output logic        rd_req,
    output logic [31:0] rd_addr,
    input  logic        rd_rdy,
    input  logic        ret_valid,
    input  logic        ret_last,
    input  logic [31:0] ret_data,
    // memory write
    output logic        wr_req,
    output logic [31:0] wr_addr,
    output line_t       wr_data,
    input  logic        wr_rdy
);

    logic               lookup_en;
    logic [INDEX_W-1:0] lookup_index;
    logic [TAG_W-1:0]   lookup_tag;
    logic               hit;
    logic               hit_way;
    tag_entry_t         way_entry [WAYS];
    logic               wr_en;
    logic               wr_way;
    logic               wr_dirty;
    logic               from_refill;
    cpu_req_t           cur_req;
    line_t              refill_line;
    logic               fill_done;

    cache_ctrl u_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .valid        (valid),
        .req          (req),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .hit          (hit),
        .hit_way      (hit_way),
        .way_entry    (way_entry),
        .fill_done    (fill_done),
        .rd_rdy       (rd_rdy),
        .wr_rdy       (wr_rdy),
        .rd_req       (rd_req),
        .wr_req       (wr_req),
        .rd_addr      (rd_addr),
        .wr_addr      (wr_addr),
        .lookup_en    (lookup_en),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .wr_en        (wr_en),
        .wr_way       (wr_way),
        .wr_dirty     (wr_dirty),
        .from_refill  (from_refill),
        .cur_req      (cur_req)
    );

    tag_store u_tags (
        .clk          (clk),
        .resetn       (resetn),
        .lookup_en    (lookup_en),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .wr_en        (wr_en),
        .wr_way       (wr_way),
        .wr_dirty     (wr_dirty),
        .hit          (hit),
        .hit_way      (hit_way),
        .way_entry    (way_entry)
    );

    // wr_way points at the victim outside the lookup cycle
    data_store u_data (
        .clk          (clk),
        .lookup_en    (lookup_en),
        .lookup_index (lookup_index),
        .hit_way      (hit_way),
        .wr_en        (wr_en),
        .wr_way       (wr_way),
        .from_refill  (from_refill),
        .cur_req      (cur_req),
        .refill_line  (refill_line),
        .victim_way   (wr_way),
        .rdata        (rdata),
        .victim_line  (wr_data)
    );

    refill_buffer u_refill (
        .clk         (clk),
        .resetn      (resetn),
        .ret_valid   (ret_valid),
        .ret_last    (ret_last),
        .ret_data    (ret_data),
        .refill_line (refill_line),
        .fill_done   (fill_done)
    );

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD = 5
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #HALF_PERIOD clk = ~clk;
    end

endmodule

`default_nettype wire

//--- dv/cache_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cache_assert import cache_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        rd_req,
    input  logic        rd_rdy,
    input  logic        wr_req,
    input  logic        wr_rdy,
    input  logic [31:0] wr_addr,
    input  line_t       wr_data,
    input  logic        data_ok
);

    // read by the testbench to stop the run
    int unsigned fail_count = 0;

    a_rd_hold: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req)
        else begin
            fail_count++;
            $error("rd_req dropped before rd_rdy");
        end

    // address and line stay put while the write waits
    a_wr_hold: assert property (@(posedge clk) disable iff (!resetn)
        wr_req && !wr_rdy |=> wr_req && $stable(wr_addr) && $stable(wr_data))
        else begin
            fail_count++;
            $error("wr_req dropped or changed before wr_rdy");
        end

    a_one_port: assert property (@(posedge clk) disable iff (!resetn)
        !(rd_req && wr_req))
        else begin
            fail_count++;
            $error("rd_req and wr_req high together");
        end

    a_data_ok_pulse: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |=> !data_ok)
        else begin
            fail_count++;
            $error("data_ok high in two consecutive cycles");
        end

endmodule

`default_nettype wire

//--- dv/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb
    import cache_pkg::*;
();

    localparam int N_OPS          = 400;
    localparam int TIMEOUT_CYCLES = N_OPS * 60;
    localparam int MEM_WORDS      = 1024;

    typedef struct packed {
        logic        is_read;
        logic        expect_hit;
        logic [31:0] rdata;
        logic [31:0] accept_cycle;
    } expect_t;

    logic        clk;
    logic        resetn;
    logic        valid;
    cpu_req_t    req;
    logic        addr_ok;
    logic        data_ok;
    logic [31:0] rdata;
    logic        rd_req;
    logic [31:0] rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    logic        ret_last;
    logic [31:0] ret_data;
    logic        wr_req;
    logic [31:0] wr_addr;
    line_t       wr_data;
    logic        wr_rdy;

    // backing memory seen by the DUT, and the expected contents
    logic [31:0] mem     [MEM_WORDS];
    logic [31:0] ref_mem [MEM_WORDS];
    expect_t     exp_q   [$];
    logic [31:0] cycles;
    int          wb_count;
    int          ops_done;
    logic [26:0] last_line;
    logic        burst_on;
    logic [2:0]  beat_idx;
    logic [31:0] burst_base;

    tb_clock #(.HALF_PERIOD(5)) u_clock (.clk(clk));

    cache_top dut (.*);

    bind cache_top cache_assert u_assert (
        .clk     (clk),
        .resetn  (resetn),
        .rd_req  (rd_req),
        .rd_rdy  (rd_rdy),
        .wr_req  (wr_req),
        .wr_rdy  (wr_rdy),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .data_ok (data_ok)
    );

    // 4 tags x 32 sets x 8 words folded into 1024 entries
    function automatic int mem_idx(logic [31:0] addr);
        return {addr[13:12], addr[9:5], addr[4:2]};
    endfunction

    function automatic logic [31:0] make_addr(int tag, int set, int word);
        return {18'b0, tag[1:0], 2'b00, set[4:0], word[2:0], 2'b00};
    endfunction

    function automatic logic [31:0] fill_word(logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    function automatic logic [31:0] ref_word(logic [31:0] addr);
        return ref_mem[mem_idx(addr)];
    endfunction

    function automatic line_t ref_line(logic [31:0] addr);
        line_t line;
        for (int i = 0; i < LINE_WORDS; i++) begin
            line[i*32 +: 32] = ref_mem[mem_idx({addr[31:5], 5'b0}) + i];
        end
        return line;
    endfunction

    function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] data,
                                                logic [3:0] strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old & ~mask) | (data & mask);
    endfunction

    task automatic fail_run(string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check(string name, logic [255:0] got, logic [255:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t ns: %s got %0h expected %0h",
                               $time, name, got, exp));
        end
    endtask

    // one request, held until accepted, then wait for its data_ok
    task automatic run_op(op_e op, logic [31:0] addr, logic [3:0] strb, logic [31:0] data);
        cpu_req_t r;
        expect_t  e;
        r.op       = op;
        r.addr.raw = addr;
        r.wstrb    = strb;
        r.wdata    = data;
        valid <= 1'b1;
        req   <= r;
        do @(posedge clk); while (!addr_ok);
        valid <= 1'b0;
        e.is_read      = (op == OP_READ);
        e.expect_hit   = (addr[31:5] == last_line);
        e.rdata        = ref_word(addr);
        e.accept_cycle = cycles;
        exp_q.push_back(e);
        if (op == OP_WRITE) begin
            ref_mem[mem_idx(addr)] = merge_bytes(ref_word(addr), data, strb);
        end
        last_line = addr[31:5];
        do @(posedge clk); while (!data_ok);
        ops_done++;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            fail_run("timeout: the run did not finish within the cycle limit");
        end
        if (dut.u_assert.fail_count != 0) begin
            fail_run("a memory port or data_ok protocol assertion failed");
        end
    end

    // response checker
    always @(posedge clk) begin
        expect_t e;
        if (resetn && data_ok) begin
            if (exp_q.size() == 0) begin
                fail_run("data_ok pulsed with no request outstanding");
            end else begin
                e = exp_q.pop_front();
                if (e.is_read) begin
                    check("rdata", rdata, e.rdata);
                end
                if (e.expect_hit) begin
                    check("hit latency", cycles - e.accept_cycle, 1);
                    check("rd_req", rd_req, 0);
                end
            end
        end
    end

    // memory model with random ready and beat gaps
    always @(posedge clk) begin
        if (!resetn) begin
            rd_rdy    <= 1'b0;
            wr_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            burst_on  <= 1'b0;
            beat_idx  <= '0;
        end else begin
            rd_rdy    <= ($urandom_range(3) != 0);
            wr_rdy    <= ($urandom_range(3) != 0);
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            if (wr_req && wr_rdy) begin
                check("wr_addr", wr_addr[4:0], 0);
                check("wr_data", wr_data, ref_line(wr_addr));
                for (int i = 0; i < LINE_WORDS; i++) begin
                    mem[mem_idx(wr_addr) + i] = wr_data[i*32 +: 32];
                end
                wb_count <= wb_count + 1;
            end
            if (rd_req && rd_rdy) begin
                check("rd_addr", rd_addr[4:0], 0);
                burst_on   <= 1'b1;
                burst_base <= rd_addr;
                beat_idx   <= '0;
            end else if (burst_on && $urandom_range(2) != 0) begin
                ret_valid <= 1'b1;
                ret_last  <= (beat_idx == 3'd7);
                ret_data  <= mem[mem_idx(burst_base) + beat_idx];
                beat_idx  <= beat_idx + 1'b1;
                if (beat_idx == 3'd7) begin
                    burst_on <= 1'b0;
                end
            end
        end
    end

    initial begin
        logic [31:0] a;
        void'($urandom(9281));
        resetn     = 1'b0;
        valid      = 1'b0;
        req        = '0;
        rd_rdy     = 1'b0;
        wr_rdy     = 1'b0;
        ret_valid  = 1'b0;
        ret_last   = 1'b0;
        ret_data   = '0;
        cycles     = '0;
        wb_count   = 0;
        ops_done   = 0;
        last_line  = '1;
        burst_on   = 1'b0;
        beat_idx   = '0;
        burst_base = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            a          = make_addr(i >> 8, (i >> 3) & 31, i & 7);
            mem[i]     = fill_word(a);
            ref_mem[i] = mem[i];
        end
        repeat (8) @(posedge clk);
        resetn <= 1'b1;

        // quiet ports while nothing is requested
        repeat (6) begin
            @(posedge clk);
            check("addr_ok", addr_ok, 0);
            check("rd_req", rd_req, 0);
            check("wr_req", wr_req, 0);
            check("data_ok", data_ok, 0);
        end

        // three dirty lines in set 5, the third evicts the first
        for (int t = 0; t < 3; t++) begin
            run_op(OP_WRITE, make_addr(t, 5, t), 4'hf, $urandom);
        end
        check("wb_count", wb_count, 1);
        for (int t = 0; t < 3; t++) begin
            run_op(OP_READ, make_addr(t, 5, t), 4'h0, 32'h0);
        end

        // partial store then read back of the same word
        run_op(OP_WRITE, make_addr(1, 9, 3), 4'b0101, $urandom);
        run_op(OP_READ, make_addr(1, 9, 3), 4'h0, 32'h0);

        while (ops_done < N_OPS) begin
            if ($urandom_range(1) == 1) begin
                a = {last_line, 5'b0} | ($urandom_range(7) << 2);
            end else begin
                a = make_addr($urandom_range(3), $urandom_range(15), $urandom_range(7));
            end
            if ($urandom_range(1) == 1) begin
                run_op(OP_WRITE, a, $urandom_range(1, 15), $urandom);
            end else begin
                run_op(OP_READ, a, 4'h0, 32'h0);
            end
        end

        // a few idle cycles so a stray data_ok still reaches the checker
        repeat (4) @(posedge clk);
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- cache_top.f
verilog/cache_pkg.sv
verilog/refill_buffer.sv
verilog/tag_store.sv
verilog/data_store.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
dv/tb_clock.sv
dv/cache_assert.sv
dv/cache_tb.sv

//--- Bender.yml
package:
  name: cache_top

sources:
  - verilog/cache_pkg.sv
  - verilog/refill_buffer.sv
  - verilog/tag_store.sv
  - verilog/data_store.sv
  - verilog/cache_ctrl.sv
  - verilog/cache_top.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/cache_assert.sv
      - dv/cache_tb.sv
